//--- sim.f
src/udp_echo_pkg.sv
src/frame_rx_parser.sv
src/payload_fifo.sv
src/reply_tx_builder.sv
src/udp_echo_top.sv
bench/udp_echo_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     := --timing --assert -Wno-fatal
TOP       := udp_echo_tb
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/udp_echo_tb.sv
`timescale 1ns/1ps

module udp_echo_tb;

    localparam logic [47:0] LOCAL_MAC     = 48'h02_00_00_00_00_00;
    localparam logic [31:0] LOCAL_IP      = 32'hc0a8_0180;
    localparam logic [15:0] ECHO_PORT     = 16'd1234;
    localparam int          MAX_PAYLOAD   = 64;
    localparam int          FRAME_CREDITS = 2;
    localparam logic [31:0] SEED          = 32'ha297_b158;
    localparam int          DRAIN_LIMIT   = 5000;

    logic                       clk = 1'b0;
    logic                       rst;
    udp_echo_pkg::stream_beat_t rx_beat_i;
    logic                       rx_valid_i;
    udp_echo_pkg::stream_beat_t tx_beat_o;
    logic                       tx_valid_o;
    logic                       tx_ready_i;

    // Fields of the next generated frame
    logic [47:0] f_dst_mac;
    logic [47:0] f_src_mac;
    logic [15:0] f_ethertype;
    logic [7:0]  f_ver_ihl;
    logic [7:0]  f_proto;
    logic [31:0] f_src_ip;
    logic [31:0] f_dst_ip;
    logic [15:0] f_src_port;
    logic [15:0] f_dst_port;
    logic [15:0] f_udp_len;
    logic [7:0]  f_payload [$];
    int          f_pad;
    int          f_cut;

    logic [7:0]                 frame [$];
    logic [7:0]                 reply [$];
    udp_echo_pkg::stream_beat_t sb [$];

    logic [31:0] data_rng = SEED;
    logic [31:0] gap_rng = SEED ^ 32'h6c07_8965;
    int          ready_mode = 0;
    logic        fired_q;
    string       test_name;
    int          errors;
    int          errors_at_start;
    int          tests_run;
    int          tests_failed;

    udp_echo_top #(
        .LOCAL_MAC     (LOCAL_MAC),
        .LOCAL_IP      (LOCAL_IP),
        .ECHO_PORT     (ECHO_PORT),
        .MAX_PAYLOAD   (MAX_PAYLOAD),
        .FRAME_CREDITS (FRAME_CREDITS)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .rx_beat_i  (rx_beat_i),
        .rx_valid_i (rx_valid_i),
        .tx_beat_o  (tx_beat_o),
        .tx_valid_o (tx_valid_o),
        .tx_ready_i (tx_ready_i)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Ones' complement of the ones'-complement sum of ten words
    function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + 32'(hdr[16*i +: 16]);
        end
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
        return ~sum[15:0];
    endfunction

    function automatic bit reply_expected();
        return sb.size() != 0;
    endfunction

    function automatic udp_echo_pkg::stream_beat_t expected_beat();
        return (sb.size() != 0) ? sb[0] : '0;
    endfunction

    task automatic report_mismatch();
        udp_echo_pkg::stream_beat_t exp;
        exp = expected_beat();
        $display("ERROR %s: expected data %02h last %0d, actual data %02h last %0d",
                 test_name, exp.data, exp.last, tx_beat_o.data, tx_beat_o.last);
        errors++;
    endtask

    task automatic report_unexpected();
        $display("%s: the DUT sent a reply byte %02h that no accepted frame explains",
                 test_name, tx_beat_o.data);
        errors++;
    endtask

    assert property (@(posedge clk) disable iff (rst)
        tx_valid_o && tx_ready_i |-> reply_expected())
        else report_unexpected();

    assert property (@(posedge clk) disable iff (rst)
        tx_valid_o && tx_ready_i && reply_expected() |-> tx_beat_o == expected_beat())
        else report_mismatch();

    // Scoreboard head leaves one half cycle after its beat transferred
    always @(posedge clk) begin
        fired_q <= !rst && tx_valid_o && tx_ready_i;
    end

    always @(negedge clk) begin
        if (fired_q && sb.size() != 0) begin
            void'(sb.pop_front());
        end
    end

    // 0 always ready, 1 random gaps, 2 held low
    always @(negedge clk) begin
        gap_rng <= xorshift32(gap_rng);
        case (ready_mode)
            1: tx_ready_i <= gap_rng[1:0] != 2'b00;
            2: tx_ready_i <= 1'b0;
            default: tx_ready_i <= 1'b1;
        endcase
    end

    task automatic put_bytes(input bit to_reply, input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            if (to_reply) begin
                reply.push_back(v[8*i +: 8]);
            end else begin
                frame.push_back(v[8*i +: 8]);
            end
        end
    endtask

    task automatic default_frame();
        f_dst_mac   = LOCAL_MAC;
        f_src_mac   = 48'h00_1b_21_3c_4d_5e;
        f_ethertype = 16'h0800;
        f_ver_ihl   = 8'h45;
        f_proto     = 8'd17;
        f_src_ip    = 32'hc0a8_0164;
        f_dst_ip    = LOCAL_IP;
        f_src_port  = 16'd50123;
        f_dst_port  = ECHO_PORT;
        f_pad       = 0;
        f_cut       = 0;
    endtask

    task automatic random_payload(input int n);
        f_payload.delete();
        repeat (n) begin
            data_rng = xorshift32(data_rng);
            f_payload.push_back(data_rng[7:0]);
        end
        f_udp_len = 16'(8 + n);
    endtask

    task automatic send_frame(input bit echo);
        logic [159:0]               ip_hdr;
        udp_echo_pkg::stream_beat_t beat;
        frame.delete();
        reply.delete();
        put_bytes(0, f_dst_mac, 6);
        put_bytes(0, f_src_mac, 6);
        put_bytes(0, f_ethertype, 2);
        put_bytes(0, {f_ver_ihl, 8'h00, f_udp_len + 16'd20, 16'h1c46, 16'h4000}, 8);
        put_bytes(0, {8'd32, f_proto, 16'h0000}, 4);
        put_bytes(0, f_src_ip, 4);
        put_bytes(0, f_dst_ip, 4);
        put_bytes(0, {f_src_port, f_dst_port, f_udp_len}, 6);
        put_bytes(0, 16'hbeef, 2);
        foreach (f_payload[i]) begin
            frame.push_back(f_payload[i]);
        end
        repeat (f_pad) begin
            frame.push_back(8'h00);
        end
        while (f_cut > 0 && frame.size() > f_cut) begin
            void'(frame.pop_back());
        end

        if (echo) begin
            ip_hdr = {16'h4500, f_udp_len + 16'd20, 32'h0000_0000, 8'd64, 8'd17, 16'h0000,
                      LOCAL_IP, f_src_ip};
            ip_hdr[79:64] = ip_checksum(ip_hdr);
            put_bytes(1, f_src_mac, 6);
            put_bytes(1, LOCAL_MAC, 6);
            put_bytes(1, 16'h0800, 2);
            for (int w = 9; w >= 0; w--) begin
                put_bytes(1, ip_hdr[16*w +: 16], 2);
            end
            put_bytes(1, {f_dst_port, f_src_port, f_udp_len}, 6);
            put_bytes(1, 16'h0000, 2);
            for (int i = 0; i < int'(f_udp_len) - 8; i++) begin
                reply.push_back(f_payload[i]);
            end
            foreach (reply[i]) begin
                beat.data = reply[i];
                beat.last = (i == reply.size() - 1);
                sb.push_back(beat);
            end
        end

        foreach (frame[i]) begin
            @(negedge clk);
            rx_valid_i     = 1'b1;
            rx_beat_i.data = frame[i];
            rx_beat_i.last = (i == frame.size() - 1);
        end
        @(negedge clk);
        rx_valid_i = 1'b0;
        rx_beat_i  = '0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (sb.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (sb.size() != 0) begin
            $display("%s: timed out with %0d reply bytes still missing",
                     test_name, sb.size());
            errors++;
            sb.delete();
        end
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        idle_cycles(4);
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", test_name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        rst          = 1'b1;
        rx_valid_i   = 1'b0;
        rx_beat_i    = '0;
        tx_ready_i   = 1'b1;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        repeat (4) @(negedge clk);
        rst = 1'b0;
        idle_cycles(2);

        start_test("echo");
        default_frame();
        random_payload(16);
        send_frame(1);
        wait_drain();
        end_test();

        start_test("filter");
        default_frame();
        f_dst_port = 16'd1235;
        random_payload(8);
        send_frame(0);
        default_frame();
        f_dst_ip = 32'hc0a8_0181;
        random_payload(8);
        send_frame(0);
        default_frame();
        f_proto = 8'd6;
        random_payload(8);
        send_frame(0);
        default_frame();
        f_ethertype = 16'h86dd;
        random_payload(8);
        send_frame(0);
        default_frame();
        random_payload(MAX_PAYLOAD + 1);
        send_frame(0);
        idle_cycles(60);
        default_frame();
        random_payload(12);
        send_frame(1);
        wait_drain();
        end_test();

        // Frames go in pairs so both fit the two credits
        start_test("backpressure");
        ready_mode <= 1;
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 2; k++) begin
                default_frame();
                f_src_port = 16'(40000 + 2 * r + k);
                data_rng = xorshift32(data_rng);
                random_payload(int'(data_rng[5:0]) + 1);
                send_frame(1);
            end
            wait_drain();
        end
        ready_mode <= 0;
        end_test();

        start_test("credits");
        ready_mode <= 2;
        for (int k = 0; k < 3; k++) begin
            default_frame();
            f_src_port = 16'(41000 + k);
            random_payload(24);
            send_frame(k < 2);
        end
        idle_cycles(10);
        ready_mode <= 0;
        wait_drain();
        idle_cycles(100);
        default_frame();
        random_payload(8);
        send_frame(1);
        wait_drain();
        end_test();

        start_test("padding");
        default_frame();
        random_payload(5);
        f_pad = 20;
        send_frame(1);
        wait_drain();
        default_frame();
        random_payload(10);
        f_cut = 30;
        send_frame(0);
        idle_cycles(60);
        default_frame();
        random_payload(3);
        send_frame(1);
        wait_drain();
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- src/udp_echo_top.sv
`timescale 1ns/1ps

module udp_echo_top #(
    parameter udp_echo_pkg::mac_addr_t LOCAL_MAC     = udp_echo_pkg::DEFAULT_LOCAL_MAC,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT     = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      MAX_PAYLOAD   = udp_echo_pkg::DEFAULT_MAX_PAYLOAD,
    parameter int                      FRAME_CREDITS = udp_echo_pkg::DEFAULT_FRAME_CREDITS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_echo_pkg::stream_beat_t rx_beat_i,
    input  logic                       rx_valid_i,
    output udp_echo_pkg::stream_beat_t tx_beat_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i
);

    logic                       hdr_push;
    udp_echo_pkg::reply_hdr_t   hdr;
    logic                       credit_return;
    logic                       wr_en;
    udp_echo_pkg::stream_beat_t wr_data;
    logic                       rd_en;
    udp_echo_pkg::stream_beat_t rd_data;
    logic                       empty;

    frame_rx_parser #(
        .LOCAL_MAC     (LOCAL_MAC),
        .LOCAL_IP      (LOCAL_IP),
        .ECHO_PORT     (ECHO_PORT),
        .MAX_PAYLOAD   (MAX_PAYLOAD),
        .FRAME_CREDITS (FRAME_CREDITS)
    ) u_parser (
        .clk             (clk),
        .rst             (rst),
        .rx_beat_i       (rx_beat_i),
        .rx_valid_i      (rx_valid_i),
        .credit_return_i (credit_return),
        .hdr_push_o      (hdr_push),
        .hdr_o           (hdr),
        .wr_en_o         (wr_en),
        .wr_data_o       (wr_data)
    );

    // Room for one full payload per credit
    payload_fifo #(
        .DEPTH (FRAME_CREDITS * MAX_PAYLOAD)
    ) u_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_data_o (rd_data),
        .empty_o   (empty)
    );

    reply_tx_builder #(
        .LOCAL_MAC     (LOCAL_MAC),
        .LOCAL_IP      (LOCAL_IP),
        .FRAME_CREDITS (FRAME_CREDITS)
    ) u_builder (
        .clk             (clk),
        .rst             (rst),
        .hdr_push_i      (hdr_push),
        .hdr_i           (hdr),
        .rd_data_i       (rd_data),
        .fifo_empty_i    (empty),
        .rd_en_o         (rd_en),
        .tx_beat_o       (tx_beat_o),
        .tx_valid_o      (tx_valid_o),
        .tx_ready_i      (tx_ready_i),
        .credit_return_o (credit_return)
    );

endmodule

//--- src/reply_tx_builder.sv
`timescale 1ns/1ps

module reply_tx_builder #(
    parameter udp_echo_pkg::mac_addr_t LOCAL_MAC     = udp_echo_pkg::DEFAULT_LOCAL_MAC,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter int                      FRAME_CREDITS = udp_echo_pkg::DEFAULT_FRAME_CREDITS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       hdr_push_i,
    input  udp_echo_pkg::reply_hdr_t   hdr_i,
    input  udp_echo_pkg::stream_beat_t rd_data_i,
    input  logic                       fifo_empty_i,
    output logic                       rd_en_o,
    output udp_echo_pkg::stream_beat_t tx_beat_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    output logic                       credit_return_o
);

    localparam int QW = (FRAME_CREDITS > 1) ? $clog2(FRAME_CREDITS) : 1;
    localparam int CW = $clog2(FRAME_CREDITS + 1);
    localparam logic [5:0] LAST_HDR_IDX = 6'(udp_echo_pkg::HDR_BYTES - 1);

    typedef enum logic [1:0] {IDLE, HEADER, PAYLOAD} tx_state_t;

    tx_state_t state;
    udp_echo_pkg::reply_hdr_t hdr_q [FRAME_CREDITS];
    logic [QW-1:0] q_wr_ptr;
    logic [QW-1:0] q_rd_ptr;
    logic [CW-1:0] q_count;
    logic q_pop;

    udp_echo_pkg::reply_hdr_t cur;
    logic [5:0] byte_idx;
    udp_echo_pkg::length_t ip_total_len;
    logic [19:0] csum_sum;
    logic [16:0] csum_fold;
    logic [15:0] csum_wrap;
    logic [15:0] ip_csum;
    logic [8*udp_echo_pkg::HDR_BYTES-1:0] hdr_bytes;

    assign q_pop = (state == IDLE) && (q_count != '0);

    always_ff @(posedge clk) begin
        if (hdr_push_i) begin
            hdr_q[q_wr_ptr] <= hdr_i;
        end
        if (q_pop) begin
            cur <= hdr_q[q_rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
        end else begin
            if (hdr_push_i) begin
                q_wr_ptr <= (q_wr_ptr == QW'(FRAME_CREDITS - 1)) ? '0 : q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= (q_rd_ptr == QW'(FRAME_CREDITS - 1)) ? '0 : q_rd_ptr + 1'b1;
            end
            if (hdr_push_i && !q_pop) begin
                q_count <= q_count + 1'b1;
            end else if (q_pop && !hdr_push_i) begin
                q_count <= q_count - 1'b1;
            end
        end
    end

    // IPv4 header checksum over the ten words, checksum field as zero
    assign ip_total_len = cur.udp_len + 16'd20;
    assign csum_sum = 20'h0_4500
                    + 20'(ip_total_len)
                    + 20'({udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP})
                    + 20'(LOCAL_IP[31:16])
                    + 20'(LOCAL_IP[15:0])
                    + 20'(cur.peer_ip[31:16])
                    + 20'(cur.peer_ip[15:0]);
    assign csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
    assign csum_wrap = csum_fold[15:0] + 16'(csum_fold[16]);
    assign ip_csum   = ~csum_wrap;

    assign hdr_bytes = {cur.peer_mac, LOCAL_MAC, udp_echo_pkg::ETHERTYPE_IPV4,
                        8'h45, 8'h00, ip_total_len, 16'h0000, 16'h0000,
                        udp_echo_pkg::REPLY_TTL, udp_echo_pkg::IP_PROTO_UDP, ip_csum,
                        LOCAL_IP, cur.peer_ip,
                        cur.local_port, cur.peer_port, cur.udp_len, 16'h0000};

    always_comb begin
        tx_valid_o = 1'b0;
        tx_beat_o  = '0;
        rd_en_o    = 1'b0;
        case (state)
            HEADER: begin
                tx_valid_o     = 1'b1;
                tx_beat_o.data = hdr_bytes[8*(LAST_HDR_IDX - byte_idx) +: 8];
                // Empty payload ends the reply on the header
                tx_beat_o.last = (byte_idx == LAST_HDR_IDX)
                    && (cur.udp_len == udp_echo_pkg::length_t'(udp_echo_pkg::UDP_HDR_BYTES));
            end
            PAYLOAD: begin
                tx_valid_o = !fifo_empty_i;
                tx_beat_o  = rd_data_i;
                rd_en_o    = !fifo_empty_i && tx_ready_i;
            end
            default: begin
                tx_valid_o = 1'b0;
            end
        endcase
    end

    assign credit_return_o = tx_valid_o && tx_ready_i && tx_beat_o.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            byte_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (q_pop) begin
                        state    <= HEADER;
                        byte_idx <= '0;
                    end
                end
                HEADER: begin
                    if (tx_ready_i) begin
                        if (byte_idx == LAST_HDR_IDX) begin
                            state <= tx_beat_o.last ? IDLE : PAYLOAD;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (credit_return_o) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_beat_o));

endmodule

//--- src/payload_fifo.sv
`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH = 128
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wr_en_i,
    input  udp_echo_pkg::stream_beat_t wr_data_i,
    input  logic                       rd_en_i,
    output udp_echo_pkg::stream_beat_t rd_data_o,
    output logic                       empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    udp_echo_pkg::stream_beat_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic full;

    assign empty_o   = count == '0;
    assign full      = count == CW'(DEPTH);
    // First word fall through
    assign rd_data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_ptr] <= wr_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en_i && !rd_en_i) begin
                count <= count + 1'b1;
            end else if (rd_en_i && !wr_en_i) begin
                count <= count - 1'b1;
            end
        end
    end

    // Credits in the parser must keep the buffer from overflowing
    assert property (@(posedge clk) disable iff (rst) wr_en_i |-> !full);

    assert property (@(posedge clk) disable iff (rst) rd_en_i |-> !empty_o);

endmodule

//--- src/frame_rx_parser.sv
`timescale 1ns/1ps

module frame_rx_parser #(
    parameter udp_echo_pkg::mac_addr_t LOCAL_MAC     = udp_echo_pkg::DEFAULT_LOCAL_MAC,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP      = udp_echo_pkg::DEFAULT_LOCAL_IP,
    parameter udp_echo_pkg::udp_port_t ECHO_PORT     = udp_echo_pkg::DEFAULT_ECHO_PORT,
    parameter int                      MAX_PAYLOAD   = udp_echo_pkg::DEFAULT_MAX_PAYLOAD,
    parameter int                      FRAME_CREDITS = udp_echo_pkg::DEFAULT_FRAME_CREDITS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  udp_echo_pkg::stream_beat_t rx_beat_i,
    input  logic                       rx_valid_i,
    input  logic                       credit_return_i,
    output logic                       hdr_push_o,
    output udp_echo_pkg::reply_hdr_t   hdr_o,
    output logic                       wr_en_o,
    output udp_echo_pkg::stream_beat_t wr_data_o
);

    localparam int CW = $clog2(FRAME_CREDITS + 1);
    localparam logic [5:0] LAST_HDR_IDX = 6'(udp_echo_pkg::HDR_BYTES - 1);

    typedef enum logic [1:0] {HEADER, PAYLOAD, SKIP} rx_state_t;

    rx_state_t state;
    logic [5:0] byte_cnt;
    logic [CW-1:0] credits;
    udp_echo_pkg::length_t payload_left;

    // Header fields, shifted in MSB first
    udp_echo_pkg::mac_addr_t dst_mac;
    udp_echo_pkg::mac_addr_t src_mac;
    logic [15:0] ethertype;
    udp_echo_pkg::byte_t ver_ihl;
    udp_echo_pkg::byte_t protocol;
    udp_echo_pkg::ip_addr_t src_ip;
    udp_echo_pkg::ip_addr_t dst_ip;
    udp_echo_pkg::udp_port_t src_port;
    udp_echo_pkg::udp_port_t dst_port;
    udp_echo_pkg::length_t udp_len;

    logic has_payload;
    logic accept;

    assign has_payload = udp_len != udp_echo_pkg::length_t'(udp_echo_pkg::UDP_HDR_BYTES);

    // Filter, evaluated while the last header byte is taken
    assign accept = ((dst_mac == LOCAL_MAC) || (dst_mac == '1))
                 && (ethertype == udp_echo_pkg::ETHERTYPE_IPV4)
                 && (ver_ihl[3:0] == 4'd5)
                 && (protocol == udp_echo_pkg::IP_PROTO_UDP)
                 && (dst_ip == LOCAL_IP)
                 && (dst_port == ECHO_PORT)
                 && (udp_len >= udp_echo_pkg::length_t'(udp_echo_pkg::UDP_HDR_BYTES))
                 && (udp_len <= udp_echo_pkg::length_t'(udp_echo_pkg::UDP_HDR_BYTES
                                                         + MAX_PAYLOAD))
                 && (credits != '0)
                 && (!rx_beat_i.last || !has_payload);

    always_ff @(posedge clk) begin
        if (rx_valid_i && state == HEADER) begin
            if (byte_cnt <= 6'd5) begin
                dst_mac <= {dst_mac[39:0], rx_beat_i.data};
            end else if (byte_cnt <= 6'd11) begin
                src_mac <= {src_mac[39:0], rx_beat_i.data};
            end else if (byte_cnt <= 6'd13) begin
                ethertype <= {ethertype[7:0], rx_beat_i.data};
            end else if (byte_cnt == 6'd14) begin
                ver_ihl <= rx_beat_i.data;
            end else if (byte_cnt == 6'd23) begin
                protocol <= rx_beat_i.data;
            end else if (byte_cnt >= 6'd26 && byte_cnt <= 6'd29) begin
                src_ip <= {src_ip[23:0], rx_beat_i.data};
            end else if (byte_cnt >= 6'd30 && byte_cnt <= 6'd33) begin
                dst_ip <= {dst_ip[23:0], rx_beat_i.data};
            end else if (byte_cnt >= 6'd34 && byte_cnt <= 6'd35) begin
                src_port <= {src_port[7:0], rx_beat_i.data};
            end else if (byte_cnt >= 6'd36 && byte_cnt <= 6'd37) begin
                dst_port <= {dst_port[7:0], rx_beat_i.data};
            end else if (byte_cnt >= 6'd38 && byte_cnt <= 6'd39) begin
                udp_len <= {udp_len[7:0], rx_beat_i.data};
            end
        end

        if (rx_valid_i && state == HEADER && byte_cnt == LAST_HDR_IDX && accept) begin
            hdr_o.peer_mac   <= src_mac;
            hdr_o.peer_ip    <= src_ip;
            hdr_o.peer_port  <= src_port;
            hdr_o.local_port <= dst_port;
            hdr_o.udp_len    <= udp_len;
            payload_left     <= udp_len - udp_echo_pkg::length_t'(udp_echo_pkg::UDP_HDR_BYTES);
        end else if (rx_valid_i && state == PAYLOAD) begin
            payload_left <= payload_left - 1'b1;
        end

        if (rx_valid_i && state == PAYLOAD) begin
            wr_data_o.data <= rx_beat_i.data;
            // An early end of frame still closes the payload
            wr_data_o.last <= (payload_left == 16'd1) || rx_beat_i.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= HEADER;
            byte_cnt   <= '0;
            hdr_push_o <= 1'b0;
            wr_en_o    <= 1'b0;
        end else begin
            hdr_push_o <= 1'b0;
            wr_en_o    <= 1'b0;
            if (rx_valid_i) begin
                case (state)
                    HEADER: begin
                        if (byte_cnt == LAST_HDR_IDX) begin
                            byte_cnt <= '0;
                            if (accept) begin
                                hdr_push_o <= 1'b1;
                            end
                            if (accept && has_payload) begin
                                state <= PAYLOAD;
                            end else if (!rx_beat_i.last) begin
                                state <= SKIP;
                            end
                        end else if (rx_beat_i.last) begin
                            // Runt frame
                            byte_cnt <= '0;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                    PAYLOAD: begin
                        wr_en_o <= 1'b1;
                        if (rx_beat_i.last) begin
                            state <= HEADER;
                        end else if (payload_left == 16'd1) begin
                            state <= SKIP;
                        end
                    end
                    default: begin
                        if (rx_beat_i.last) begin
                            state <= HEADER;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CW'(FRAME_CREDITS);
        end else if (hdr_push_o && !credit_return_i) begin
            credits <= credits - 1'b1;
        end else if (credit_return_i && !hdr_push_o) begin
            credits <= credits + 1'b1;
        end
    end

    // Builder returns no more credits than were spent
    assert property (@(posedge clk) disable iff (rst)
        credits <= CW'(FRAME_CREDITS));

    assert property (@(posedge clk) disable iff (rst)
        hdr_push_o |-> credits != '0);

endmodule

//--- src/udp_echo_pkg.sv
package udp_echo_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] length_t;

    // One byte of an Ethernet frame on the stream
    typedef struct packed {
        byte_t data;
        logic  last;
    } stream_beat_t;

    // Everything the builder needs to form one reply
    typedef struct packed {
        mac_addr_t peer_mac;
        ip_addr_t  peer_ip;
        udp_port_t peer_port;
        udp_port_t local_port;
        length_t   udp_len;
    } reply_hdr_t;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam byte_t       IP_PROTO_UDP   = 8'd17;
    localparam byte_t       REPLY_TTL      = 8'd64;

    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int HDR_BYTES     = 42;
    localparam int UDP_HDR_BYTES = 8;

    localparam mac_addr_t DEFAULT_LOCAL_MAC     = 48'h02_00_00_00_00_00;
    localparam ip_addr_t  DEFAULT_LOCAL_IP      = {8'd192, 8'd168, 8'd1, 8'd128};
    localparam udp_port_t DEFAULT_ECHO_PORT     = 16'd1234;
    localparam int        DEFAULT_MAX_PAYLOAD   = 64;
    localparam int        DEFAULT_FRAME_CREDITS = 2;

endpackage
